/* Makefile */
VERILATOR  = verilator
TOP        = tb_cpu_axi
FILELIST   = sim.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -j 0
PASS_MSG   = Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* sim.f */
src/cpu_axi_pkg.sv
src/req_arbiter.sv
src/axi_master.sv
src/resp_router.sv
src/axi_sram.sv
src/cpu_axi_top.sv
sim/tb_cpu_axi.sv

/* sim/cpu_axi_trace.txt */
# op: 0 fetch, 1 load, 2 store, 3 load raised together with the fetch on the next line
# columns in hex: op addr wdata wstrb cancel expected_rdata
2 00000000 deadbeef f 0 00000000
1 00000000 00000000 0 0 deadbeef
2 00000004 11223344 f 0 00000000
2 00000004 aabbccdd 5 0 00000000
1 00000004 00000000 0 0 11bb33dd
2 00000008 01020304 f 0 00000000
2 00000008 ffeeddcc a 0 00000000
1 00000008 00000000 0 0 ff02dd04
2 00000000 00007700 2 0 00000000
1 00000000 00000000 0 0 dead77ef
2 0000000c 00000013 f 0 00000000
2 00000010 00100093 f 0 00000000
2 00000014 02a00513 f 0 00000000
0 0000000c 00000000 0 0 00000013
0 00000010 00000000 0 1 00100093
0 00000010 00000000 0 0 00100093
0 00000014 00000000 0 0 02a00513
2 00000020 cafef00d f 0 00000000
3 00000020 00000000 0 0 cafef00d
0 0000000c 00000000 0 0 00000013
2 000003fc 5a5aa5a5 f 0 00000000
1 000003fe 00000000 0 0 5a5aa5a5
0 00000010 00000000 0 1 00100093
3 00000004 00000000 0 0 11bb33dd
0 00000014 00000000 0 0 02a00513

/* sim/tb_cpu_axi.sv */
module tb_cpu_axi;

   localparam int mem_lat     = 2;
   localparam int mem_depth   = 256;
   localparam int cancel_wait = 20;
   // trace code for a load raised in the same cycle as the next fetch line
   localparam logic [1:0] op_pair = 2'd3;
   // core-side flags that a wait can watch
   localparam int flag_inst_addr_ok = 0;
   localparam int flag_data_addr_ok = 1;
   localparam int flag_inst_valid   = 2;
   localparam int flag_data_data_ok = 3;

   // one trace line
   typedef struct packed {
      logic [1:0]                         op;
      logic [cpu_axi_pkg::grlen-1:0]      addr;
      logic [cpu_axi_pkg::grlen-1:0]      wdata;
      logic [cpu_axi_pkg::strb_w-1:0]     wstrb;
      logic                               cancel;
      logic [cpu_axi_pkg::grlen-1:0]      exp_data;
   } trace_op_t;

   logic                                  aclk;
   logic                                  reset;
   logic                                  inst_req;
   logic [cpu_axi_pkg::grlen-1:0]         inst_addr;
   logic                                  inst_cancel;
   logic                                  inst_addr_ok;
   logic                                  inst_valid;
   logic [cpu_axi_pkg::grlen-1:0]         inst_rdata;
   logic                                  data_req;
   logic                                  data_wr;
   logic [cpu_axi_pkg::grlen-1:0]         data_addr;
   logic [cpu_axi_pkg::grlen-1:0]         data_wdata;
   logic [cpu_axi_pkg::strb_w-1:0]        data_wstrb;
   logic                                  data_addr_ok;
   logic                                  data_data_ok;
   logic [cpu_axi_pkg::grlen-1:0]         data_rdata;

   trace_op_t  ops[$];
   int         errors       = 0;
   int         tests_run    = 0;
   int         tests_failed = 0;
   int         cycles       = 0;
   int         cycle_limit  = 100;
   int         inst_pulses  = 0;
   logic [7:0] lfsr         = 8'd35;

   cpu_axi_top #(
      .mem_words   (mem_depth),
      .mem_latency (mem_lat)
   ) uut (.*);

   initial begin
      aclk = 1'b0;
      forever #50 aclk = ~aclk;
   end

   // every inst_valid cycle, to catch double pulses
   always @(negedge aclk) begin
      if (inst_valid) begin
         inst_pulses <= inst_pulses + 1;
      end
   end

   // watchdog, limit set once the trace length is known
   initial begin
      while (cycles < cycle_limit) begin
         @(posedge aclk);
         cycles++;
      end
      $display("ERROR: timeout, a request did not complete within %0d cycles", cycles);
      $display("Simulation finished: FAIL");
      $finish;
   end

   // galois form, taps x^8 + x^6 + x^5 + x^4 + 1
   function automatic logic [7:0] lfsr_next(input logic [7:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 8'hb8;
      end
      return s >> 1;
   endfunction

   // 0 to 3 idle cycles, two lfsr bits
   task automatic idle_gap();
      int gap;
      gap = 0;
      repeat (2) begin
         gap  = (gap << 1) | int'(lfsr[0]);
         lfsr = lfsr_next(lfsr);
      end
      repeat (gap) @(posedge aclk);
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
         errors++;
      end
   endtask

   function automatic logic flag_value(input int which);
      case (which)
         flag_inst_addr_ok: return inst_addr_ok;
         flag_data_addr_ok: return data_addr_ok;
         flag_inst_valid:   return inst_valid;
         flag_data_data_ok: return data_data_ok;
         default:           return 1'b0;
      endcase
   endfunction

   // sampled mid-cycle, combinational outputs settled
   task automatic wait_flag(input int which);
      @(negedge aclk);
      while (!flag_value(which)) @(negedge aclk);
   endtask

   task automatic report_test(input string what, input int e0);
      tests_run++;
      if (errors != e0) begin
         tests_failed++;
      end
      $display("test %0d %s: %s", tests_run, what, (errors == e0) ? "ok" : "mismatch");
   endtask

   task automatic run_data(input trace_op_t t);
      @(posedge aclk);
      #10;
      data_req   = 1'b1;
      data_wr    = (t.op == cpu_axi_pkg::op_store);
      data_addr  = t.addr;
      data_wdata = t.wdata;
      data_wstrb = t.wstrb;
      wait_flag(flag_data_addr_ok);
      // handshake on this edge, then drop
      @(posedge aclk);
      #10;
      data_req = 1'b0;
      data_wr  = 1'b0;
      wait_flag(flag_data_data_ok);
      if (t.op != cpu_axi_pkg::op_store) begin
         check_value("data_rdata", data_rdata, t.exp_data);
      end
   endtask

   // second half of a fetch, after addr_ok
   task automatic finish_fetch(input trace_op_t t, input int p0);
      @(posedge aclk);
      #10;
      inst_req = 1'b0;
      if (t.cancel) begin
         inst_cancel = 1'b1;
         @(posedge aclk);
         #10;
         inst_cancel = 1'b0;
         // response is dropped, so no flag to wait for
         repeat (cancel_wait) @(posedge aclk);
         check_value("inst_valid pulses", inst_pulses - p0, 0);
      end else begin
         wait_flag(flag_inst_valid);
         check_value("inst_rdata", inst_rdata, t.exp_data);
         repeat (2) @(posedge aclk);
         check_value("inst_valid pulses", inst_pulses - p0, 1);
      end
   endtask

   task automatic run_fetch(input trace_op_t t);
      int p0;
      p0 = inst_pulses;
      @(posedge aclk);
      #10;
      inst_req  = 1'b1;
      inst_addr = t.addr;
      wait_flag(flag_inst_addr_ok);
      finish_fetch(t, p0);
   endtask

   // load and fetch raised together, load must win
   task automatic run_pair(input trace_op_t ld, input trace_op_t fe);
      int p0;
      p0 = inst_pulses;
      @(posedge aclk);
      #10;
      data_req  = 1'b1;
      data_wr   = 1'b0;
      data_addr = ld.addr;
      inst_req  = 1'b1;
      inst_addr = fe.addr;
      wait_flag(flag_data_addr_ok);
      check_value("inst_addr_ok", 32'(inst_addr_ok), 0);
      @(posedge aclk);
      #10;
      data_req = 1'b0;
      wait_flag(flag_data_data_ok);
      check_value("data_rdata", data_rdata, ld.exp_data);
      // fetch still held, granted once the read side frees
      wait_flag(flag_inst_addr_ok);
      finish_fetch(fe, p0);
   endtask

   initial begin
      int                              fd;
      int                              n;
      int                              i;
      int                              e0;
      string                           line;
      logic [1:0]                      f_op;
      logic [cpu_axi_pkg::grlen-1:0]   f_addr;
      logic [cpu_axi_pkg::grlen-1:0]   f_wdata;
      logic [cpu_axi_pkg::strb_w-1:0]  f_wstrb;
      logic                            f_cancel;
      logic [cpu_axi_pkg::grlen-1:0]   f_exp;
      trace_op_t                       t;
      reset       = 1'b1;
      inst_req    = 1'b0;
      inst_addr   = '0;
      inst_cancel = 1'b0;
      data_req    = 1'b0;
      data_wr     = 1'b0;
      data_addr   = '0;
      data_wdata  = '0;
      data_wstrb  = '0;
      fd = $fopen("sim/cpu_axi_trace.txt", "r");
      if (fd == 0) begin
         $display("ERROR: cannot open the trace file sim/cpu_axi_trace.txt");
         errors++;
      end else begin
         // comment and blank lines do not scan as six fields
         while ($fgets(line, fd) > 0) begin
            n = $sscanf(line, "%h %h %h %h %h %h", f_op, f_addr, f_wdata, f_wstrb,
                        f_cancel, f_exp);
            if (n == 6) begin
               ops.push_back('{op: f_op, addr: f_addr, wdata: f_wdata, wstrb: f_wstrb,
                               cancel: f_cancel, exp_data: f_exp});
            end
         end
         $fclose(fd);
         if (ops.size() == 0) begin
            $display("ERROR: the trace file holds no operations");
            errors++;
         end
      end
      cycle_limit = ops.size() * (mem_lat + 30) + 100;
      repeat (5) @(posedge aclk);
      #10;
      reset = 1'b0;
      // idle outputs before the first request
      @(negedge aclk);
      e0 = errors;
      check_value("inst_addr_ok", 32'(inst_addr_ok), 0);
      check_value("data_addr_ok", 32'(data_addr_ok), 0);
      check_value("inst_valid", 32'(inst_valid), 0);
      check_value("data_data_ok", 32'(data_data_ok), 0);
      report_test("idle after reset", e0);
      i = 0;
      while (i < ops.size()) begin
         t  = ops[i];
         e0 = errors;
         idle_gap();
         if (t.op == op_pair) begin
            if (i + 1 < ops.size() && ops[i + 1].op == cpu_axi_pkg::op_fetch) begin
               run_pair(t, ops[i + 1]);
               report_test($sformatf("load %h with fetch %h", t.addr, ops[i + 1].addr), e0);
               i++;
            end else begin
               $display("ERROR: trace line %0d pairs a load with no fetch after it", i);
               errors++;
            end
         end else if (t.op == cpu_axi_pkg::op_fetch) begin
            run_fetch(t);
            report_test($sformatf("fetch %h%s", t.addr, t.cancel ? " cancelled" : ""), e0);
         end else begin
            run_data(t);
            report_test($sformatf("%s %h", (t.op == cpu_axi_pkg::op_store) ? "store" : "load",
                                  t.addr), e0);
         end
         i++;
      end
      $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

/* src/axi_master.sv */
module axi_master (
   input  logic                       aclk,
   input  logic                       reset,
   input  cpu_axi_pkg::bus_req_t      rd_req,
   input  logic                       rd_valid,
   output logic                       rd_taken,
   input  cpu_axi_pkg::bus_req_t      wr_req,
   input  logic                       wr_valid,
   output logic                       wr_taken,
   output cpu_axi_pkg::axi_ar_t       ar,
   output logic                       arvalid,
   input  logic                       arready,
   output cpu_axi_pkg::axi_wr_t       aw,
   output logic                       awvalid,
   input  logic                       awready,
   output logic                       wvalid,
   input  logic                       wready
);

   // every transfer is one beat of 4 bytes
   // len, size and burst stay fixed, so only addr, id and data move

   logic                                ar_fire;
   logic                                aw_fire;
   logic                                w_fire;
   logic                                wr_active;
   logic                                wr_start;
   logic                                aw_done;
   logic                                w_done;
   logic [cpu_axi_pkg::id_w-1:0]        rd_id;

   assign ar_fire = arvalid & arready;
   assign aw_fire = awvalid & awready;
   assign w_fire  = wvalid & wready;

   // read grant is taken as soon as the ar slot is free
   assign rd_taken = rd_valid & ~arvalid;

   // id follows the client that asked
   assign rd_id = (rd_req.op == cpu_axi_pkg::op_fetch) ? cpu_axi_pkg::ifu_id
                                                       : cpu_axi_pkg::lsu_id;

   // write starts once, then waits for both aw and w
   assign wr_start = wr_valid & ~wr_active;
   assign aw_done  = ~awvalid | awready;
   assign w_done   = ~wvalid | wready;
   assign wr_taken = wr_active & aw_done & w_done;

   // arvalid: set on take, clear on arready
   always_ff @(posedge aclk) begin
      if (reset) begin
         arvalid <= 1'b0;
      end else if (rd_taken) begin
         arvalid <= 1'b1;
      end else if (ar_fire) begin
         arvalid <= 1'b0;
      end
   end

   // ar payload, word aligned
   always_ff @(posedge aclk) begin
      if (rd_taken) begin
         ar.id   <= rd_id;
         ar.addr <= {rd_req.addr[cpu_axi_pkg::grlen-1:2], 2'b00};
      end
   end

   // aw and w valids clear independently
   always_ff @(posedge aclk) begin
      if (reset) begin
         wr_active <= 1'b0;
         awvalid   <= 1'b0;
         wvalid    <= 1'b0;
      end else if (wr_start) begin
         wr_active <= 1'b1;
         awvalid   <= 1'b1;
         wvalid    <= 1'b1;
      end else begin
         if (aw_fire) begin
            awvalid <= 1'b0;
         end
         if (w_fire) begin
            wvalid <= 1'b0;
         end
         // both channels done, release the grant
         if (wr_taken) begin
            wr_active <= 1'b0;
         end
      end
   end

   // aw/w payload held for the whole transfer
   always_ff @(posedge aclk) begin
      if (wr_start) begin
         aw.addr <= {wr_req.addr[cpu_axi_pkg::grlen-1:2], 2'b00};
         aw.data <= wr_req.wdata;
         aw.strb <= wr_req.wstrb;
      end
   end

   // ar held steady under back-pressure
   a_ar_hold : assert property (@(posedge aclk) disable iff (reset)
      arvalid && !arready |=> arvalid && $stable(ar));

endmodule

/* src/axi_sram.sv */
module axi_sram #(
   parameter int mem_words   = 256,
   parameter int mem_latency = 2
) (
   input  logic                       aclk,
   input  logic                       reset,
   input  cpu_axi_pkg::axi_ar_t       ar,
   input  logic                       arvalid,
   output logic                       arready,
   input  cpu_axi_pkg::axi_wr_t       aw,
   input  logic                       awvalid,
   output logic                       awready,
   input  logic                       wvalid,
   output logic                       wready,
   output cpu_axi_pkg::axi_r_t        r,
   output logic                       rvalid,
   input  logic                       rready,
   output cpu_axi_pkg::axi_b_t        b,
   output logic                       bvalid,
   input  logic                       bready
);

   // word index bits, byte offset dropped
   localparam int idx_w    = (mem_words > 1) ? $clog2(mem_words) : 1;
   localparam int cnt_w    = $clog2(mem_latency + 1);
   // counter preload so the response lands mem_latency cycles after the handshake
   localparam int lat_init = (mem_latency > 1) ? mem_latency - 2 : 0;

   typedef enum logic [1:0] {
      idle,
      wait_lat,
      respond
   } mem_state_e;

   logic [cpu_axi_pkg::grlen-1:0]   mem [mem_words];
   mem_state_e                      rd_state;
   mem_state_e                      wr_state;
   logic [cnt_w-1:0]                rd_cnt;
   logic [cnt_w-1:0]                wr_cnt;
   logic                            wr_rdy;
   logic                            ar_fire;
   logic                            wr_fire;
   logic [cpu_axi_pkg::id_w-1:0]    rd_id;
   logic [cpu_axi_pkg::grlen-1:0]   rd_data;

   // aw and w are accepted together
   assign awready = wr_rdy;
   assign wready  = wr_rdy;
   assign ar_fire = arvalid & arready;
   assign wr_fire = awvalid & wvalid & wr_rdy;

   assign rvalid = (rd_state == respond);
   assign bvalid = (wr_state == respond);
   assign r      = '{id: rd_id, data: rd_data, resp: cpu_axi_pkg::resp_okay, last: 1'b1};
   // writes only come from the load/store unit
   assign b      = '{id: cpu_axi_pkg::lsu_id, resp: cpu_axi_pkg::resp_okay};

   // read side fsm
   always_ff @(posedge aclk) begin
      if (reset) begin
         rd_state <= idle;
         arready  <= 1'b0;
         rd_cnt   <= '0;
      end else begin
         case (rd_state)
            idle: begin
               if (ar_fire) begin
                  arready  <= 1'b0;
                  rd_cnt   <= cnt_w'(lat_init);
                  rd_state <= (mem_latency > 1) ? wait_lat : respond;
               end else begin
                  // ready one cycle after valid
                  arready <= arvalid;
               end
            end
            wait_lat: begin
               if (rd_cnt == '0) begin
                  rd_state <= respond;
               end else begin
                  rd_cnt <= rd_cnt - 1'b1;
               end
            end
            respond: begin
               if (rready) begin
                  rd_state <= idle;
               end
            end
            default: rd_state <= idle;
         endcase
      end
   end

   // write side fsm, same shape
   always_ff @(posedge aclk) begin
      if (reset) begin
         wr_state <= idle;
         wr_rdy   <= 1'b0;
         wr_cnt   <= '0;
      end else begin
         case (wr_state)
            idle: begin
               if (wr_fire) begin
                  wr_rdy   <= 1'b0;
                  wr_cnt   <= cnt_w'(lat_init);
                  wr_state <= (mem_latency > 1) ? wait_lat : respond;
               end else begin
                  wr_rdy <= awvalid & wvalid;
               end
            end
            wait_lat: begin
               if (wr_cnt == '0) begin
                  wr_state <= respond;
               end else begin
                  wr_cnt <= wr_cnt - 1'b1;
               end
            end
            respond: begin
               if (bready) begin
                  wr_state <= idle;
               end
            end
            default: wr_state <= idle;
         endcase
      end
   end

   // read data sampled at the address handshake
   always_ff @(posedge aclk) begin
      if (ar_fire) begin
         rd_id   <= ar.id;
         rd_data <= mem[ar.addr[idx_w+1:2]];
      end
   end

   // byte merge under strobe
   always_ff @(posedge aclk) begin
      if (wr_fire) begin
         for (int i = 0; i < cpu_axi_pkg::strb_w; i++) begin
            if (aw.strb[i]) begin
               mem[aw.addr[idx_w+1:2]][8*i +: 8] <= aw.data[8*i +: 8];
            end
         end
      end
   end

   // fixed read latency
   a_rd_latency : assert property (@(posedge aclk) disable iff (reset)
      ar_fire |-> ##mem_latency rvalid);

endmodule

/* src/cpu_axi_pkg.sv */
package cpu_axi_pkg;

   // core word and address width
   localparam int grlen = 32;

   // one strobe bit per byte lane
   localparam int strb_w = grlen / 8;

   // axi id width
   localparam int id_w = 4;

   // fixed ids per client
   // fetch and load/store never share an id
   localparam logic [id_w-1:0] ifu_id = id_w'(0);
   localparam logic [id_w-1:0] lsu_id = id_w'(1);

   // axi response codes
   // only okay is produced by the slave memory
   localparam logic [1:0] resp_okay = 2'b00;

   // kind of core request
   typedef enum logic [1:0] {
      op_fetch,
      op_load,
      op_store
   } cmd_op_e;

   // one granted request, arbiter to master
   typedef struct packed {
      cmd_op_e             op;
      logic [grlen-1:0]    addr;
      logic [grlen-1:0]    wdata;
      logic [strb_w-1:0]   wstrb;
   } bus_req_t;

   // read address channel payload
   typedef struct packed {
      logic [id_w-1:0]     id;
      logic [grlen-1:0]    addr;
   } axi_ar_t;

   // aw and w travel together, single beat only
   typedef struct packed {
      logic [grlen-1:0]    addr;
      logic [grlen-1:0]    data;
      logic [strb_w-1:0]   strb;
   } axi_wr_t;

   // read data beat
   typedef struct packed {
      logic [id_w-1:0]     id;
      logic [grlen-1:0]    data;
      logic [1:0]          resp;
      logic                last;
   } axi_r_t;

   // write response
   typedef struct packed {
      logic [id_w-1:0]     id;
      logic [1:0]          resp;
   } axi_b_t;

endpackage

/* src/cpu_axi_top.sv */
module cpu_axi_top #(
   parameter int mem_words   = 256,
   parameter int mem_latency = 2
) (
   input  logic                                aclk,
   input  logic                                reset,
   // fetch port
   input  logic                                inst_req,
   input  logic [cpu_axi_pkg::grlen-1:0]       inst_addr,
   input  logic                                inst_cancel,
   output logic                                inst_addr_ok,
   output logic                                inst_valid,
   output logic [cpu_axi_pkg::grlen-1:0]       inst_rdata,
   // load/store port
   input  logic                                data_req,
   input  logic                                data_wr,
   input  logic [cpu_axi_pkg::grlen-1:0]       data_addr,
   input  logic [cpu_axi_pkg::grlen-1:0]       data_wdata,
   input  logic [cpu_axi_pkg::strb_w-1:0]      data_wstrb,
   output logic                                data_addr_ok,
   output logic                                data_data_ok,
   output logic [cpu_axi_pkg::grlen-1:0]       data_rdata
);

   // arbiter to master
   cpu_axi_pkg::bus_req_t  rd_req;
   cpu_axi_pkg::bus_req_t  wr_req;
   logic                   rd_valid;
   logic                   wr_valid;
   logic                   rd_taken;
   logic                   wr_taken;
   // router back to arbiter
   logic                   rd_is_fetch;
   logic                   fetch_cancelled;
   logic                   rd_done;
   logic                   wr_done;
   // axi master port
   cpu_axi_pkg::axi_ar_t   ar;
   cpu_axi_pkg::axi_wr_t   aw;
   cpu_axi_pkg::axi_r_t    r;
   cpu_axi_pkg::axi_b_t    b;
   logic                   arvalid;
   logic                   arready;
   logic                   awvalid;
   logic                   awready;
   logic                   wvalid;
   logic                   wready;
   logic                   rvalid;
   logic                   rready;
   logic                   bvalid;
   logic                   bready;

   req_arbiter u_arb (.*);

   axi_master u_mst (.*);

   axi_sram #(
      .mem_words   (mem_words),
      .mem_latency (mem_latency)
   ) u_mem (.*);

   resp_router u_rtr (.*);

endmodule

/* src/req_arbiter.sv */
module req_arbiter (
   input  logic                                aclk,
   input  logic                                reset,
   input  logic                                inst_req,
   input  logic [cpu_axi_pkg::grlen-1:0]       inst_addr,
   input  logic                                inst_cancel,
   output logic                                inst_addr_ok,
   input  logic                                data_req,
   input  logic                                data_wr,
   input  logic [cpu_axi_pkg::grlen-1:0]       data_addr,
   input  logic [cpu_axi_pkg::grlen-1:0]       data_wdata,
   input  logic [cpu_axi_pkg::strb_w-1:0]      data_wstrb,
   output logic                                data_addr_ok,
   output cpu_axi_pkg::bus_req_t               rd_req,
   output logic                                rd_valid,
   input  logic                                rd_taken,
   output cpu_axi_pkg::bus_req_t               wr_req,
   output logic                                wr_valid,
   input  logic                                wr_taken,
   output logic                                rd_is_fetch,
   output logic                                fetch_cancelled,
   input  logic                                rd_done,
   input  logic                                wr_done
);

   // one read and one write in flight at most
   logic rd_busy;
   logic wr_busy;
   logic cancel_q;
   logic want_store;
   logic want_load;
   logic grant_store;
   logic grant_load;
   logic grant_fetch;
   logic grant_rd;
   logic cancel_now;

   // data port carries either a store or a load
   assign want_store = data_req & data_wr;
   assign want_load  = data_req & ~data_wr;

   // priority store, load, fetch
   // a store in this cycle also holds the fetch back
   assign grant_store = want_store & ~wr_busy;
   assign grant_load  = want_load & ~rd_busy;
   assign grant_fetch = inst_req & ~rd_busy & ~want_load & ~grant_store;
   assign grant_rd    = grant_load | grant_fetch;

   // addr_ok is the grant itself, same cycle
   assign inst_addr_ok = grant_fetch;
   assign data_addr_ok = grant_store | grant_load;

   // cancel only matters for an outstanding fetch
   assign cancel_now      = inst_cancel & rd_busy & rd_is_fetch;
   assign fetch_cancelled = cancel_q | cancel_now;

   always_ff @(posedge aclk) begin
      if (reset) begin
         rd_busy     <= 1'b0;
         wr_busy     <= 1'b0;
         rd_valid    <= 1'b0;
         wr_valid    <= 1'b0;
         rd_is_fetch <= 1'b0;
         cancel_q    <= 1'b0;
      end else begin
         // busy spans grant to response
         if (grant_rd) begin
            rd_busy <= 1'b1;
         end else if (rd_done) begin
            rd_busy <= 1'b0;
         end
         if (grant_store) begin
            wr_busy <= 1'b1;
         end else if (wr_done) begin
            wr_busy <= 1'b0;
         end
         // grant register, dropped once the master takes it
         if (grant_rd) begin
            rd_valid <= 1'b1;
         end else if (rd_taken) begin
            rd_valid <= 1'b0;
         end
         if (grant_store) begin
            wr_valid <= 1'b1;
         end else if (wr_taken) begin
            wr_valid <= 1'b0;
         end
         if (grant_rd) begin
            rd_is_fetch <= grant_fetch;
         end
         // sticky cancel until the read returns
         if (rd_done) begin
            cancel_q <= 1'b0;
         end else if (cancel_now) begin
            cancel_q <= 1'b1;
         end
      end
   end

   // granted payloads
   always_ff @(posedge aclk) begin
      if (grant_rd) begin
         rd_req.op    <= grant_fetch ? cpu_axi_pkg::op_fetch : cpu_axi_pkg::op_load;
         rd_req.addr  <= grant_fetch ? inst_addr : data_addr;
         rd_req.wdata <= '0;
         rd_req.wstrb <= '0;
      end
      if (grant_store) begin
         wr_req <= '{op: cpu_axi_pkg::op_store, addr: data_addr,
                     wdata: data_wdata, wstrb: data_wstrb};
      end
   end

   // no read completes while a read grant still waits for the master
   a_rd_single : assert property (@(posedge aclk) disable iff (reset)
      rd_valid |-> rd_busy && !rd_done);

endmodule

/* src/resp_router.sv */
module resp_router (
   input  cpu_axi_pkg::axi_r_t                 r,
   input  logic                                rvalid,
   output logic                                rready,
   input  cpu_axi_pkg::axi_b_t                 b,
   input  logic                                bvalid,
   output logic                                bready,
   input  logic                                rd_is_fetch,
   input  logic                                fetch_cancelled,
   output logic                                inst_valid,
   output logic [cpu_axi_pkg::grlen-1:0]       inst_rdata,
   output logic                                data_data_ok,
   output logic [cpu_axi_pkg::grlen-1:0]       data_rdata,
   output logic                                rd_done,
   output logic                                wr_done
);

   logic r_fire;
   logic b_fire;
   logic r_ok;
   logic b_ok;
   logic r_to_ifu;
   logic r_to_lsu;
   logic b_to_lsu;

   // responses are always accepted
   assign rready = 1'b1;
   assign bready = 1'b1;

   assign r_fire = rvalid & rready;
   assign b_fire = bvalid & bready;

   // only okay completes a request
   assign r_ok = (r.resp == cpu_axi_pkg::resp_okay);
   assign b_ok = (b.resp == cpu_axi_pkg::resp_okay);

   // steer by id, cross-checked with the kind of read in flight
   assign r_to_ifu = r_fire & r_ok & rd_is_fetch & (r.id == cpu_axi_pkg::ifu_id);
   assign r_to_lsu = r_fire & r_ok & ~rd_is_fetch & (r.id == cpu_axi_pkg::lsu_id);
   assign b_to_lsu = b_fire & b_ok & (b.id == cpu_axi_pkg::lsu_id);

   // cancelled fetch is swallowed here
   assign inst_valid = r_to_ifu & ~fetch_cancelled;

   // data lanes masked to their owner
   assign inst_rdata = r.data & {cpu_axi_pkg::grlen{rd_is_fetch}};
   assign data_rdata = r.data & {cpu_axi_pkg::grlen{~rd_is_fetch}};

   // load data or store ack, one pulse
   assign data_data_ok = r_to_lsu | b_to_lsu;

   // free busy on any last beat, also for a dropped fetch
   assign rd_done = r_fire & r.last;
   assign wr_done = b_fire;

endmodule
